// File: hdl/dual_port_memory.sv
`timescale 1ns/1ps

module dual_port_memory (
    input  logic                             clk,
    input  logic                             write_enable,
    input  logic [switch_pkg::ADDR_BITS-1:0] write_address,
    input  switch_pkg::flit_t                write_data,
    input  logic                             read_enable,
    input  logic [switch_pkg::ADDR_BITS-1:0] read_address,
    output switch_pkg::flit_t                read_data
);

    switch_pkg::flit_t mem [switch_pkg::FIFO_DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_address] <= write_data;
        end
    end

    // Read port, output register keeps the last flit read
    always_ff @(posedge clk) begin
        if (read_enable) begin
            read_data <= mem[read_address];
        end
    end

endmodule

// File: hdl/fifo.sv
`timescale 1ns/1ps

module fifo (
    input  logic clk,
    input  logic reset_L,
    fifo_if.fifo fifo_bus
);

    logic [switch_pkg::ADDR_BITS-1:0]  wr_ptr;
    logic [switch_pkg::ADDR_BITS-1:0]  rd_ptr;
    logic [switch_pkg::COUNT_BITS-1:0] count;     // Occupancy
    logic                              push_ok;   // Accepted push
    logic                              pop_ok;    // Accepted pop
    logic                              refused;

    // A push into a full FIFO or a pop from an empty one never reaches the memory
    assign push_ok = fifo_bus.push && !fifo_bus.full;
    assign pop_ok  = fifo_bus.pop && !fifo_bus.empty;
    assign refused = (fifo_bus.push && fifo_bus.full) || (fifo_bus.pop && fifo_bus.empty);

    dual_port_memory u_mem (
        .clk           (clk),
        .write_enable  (push_ok),
        .write_address (wr_ptr),
        .write_data    (fifo_bus.data_in),
        .read_enable   (pop_ok),
        .read_address  (rd_ptr),
        .read_data     (fifo_bus.data_out)
    );

    // Pointers wrap on their own at the depth
    always_ff @(posedge clk) begin
        if (!reset_L) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            count <= '0;
        end else begin
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Idle, or push and pop together
            endcase
        end
    end

    // Flags come straight off the count register,
    // so they trail an accepted operation by one cycle
    assign fifo_bus.empty        = (count == '0);
    assign fifo_bus.full         = (int'(count) == switch_pkg::FIFO_DEPTH);
    assign fifo_bus.almost_empty = (int'(count) == switch_pkg::ALMOST_EMPTY_LEVEL);
    assign fifo_bus.almost_full  = (int'(count) >= switch_pkg::ALMOST_FULL_LEVEL)
                                && (int'(count) < switch_pkg::FIFO_DEPTH);

    // Single cycle error pulse
    always_ff @(posedge clk) begin
        if (!reset_L) begin
            fifo_bus.error <= 1'b0;
        end else begin
            fifo_bus.error <= refused;
        end
    end

endmodule

// File: hdl/fifo_if.sv
`timescale 1ns/1ps

interface fifo_if;

    logic                push;
    logic                pop;
    switch_pkg::flit_t   data_in;
    switch_pkg::flit_t   data_out;     // Registered read data, holds between pops
    logic                empty;
    logic                almost_empty;
    logic                almost_full;  // Doubles as the pause level
    logic                full;
    logic                error;        // One cycle pulse after a refused operation

    modport fifo (
        input  push, pop, data_in,
        output data_out, empty, almost_empty, almost_full, full, error
    );

    modport writer (
        output push, data_in,
        input  full, almost_full
    );

    modport reader (
        output pop,
        input  data_out, empty, almost_empty
    );

endinterface

// File: hdl/packet_switch.sv
`timescale 1ns/1ps

module packet_switch (
    input  logic                                clk,
    input  logic                                reset_L,

    // Ingress side
    input  logic [switch_pkg::NUM_LANES-1:0]    push_in,
    input  switch_pkg::flit_t                   data_in [switch_pkg::NUM_LANES],
    output logic [switch_pkg::NUM_LANES-1:0]    ingress_full,

    // Egress side
    input  logic [switch_pkg::NUM_LANES-1:0]    pop_out,
    output switch_pkg::flit_t                   data_out [switch_pkg::NUM_LANES],
    output logic [switch_pkg::NUM_LANES-1:0]    egress_empty,

    // Refused push per ingress lane, refused pop per egress lane
    output logic [switch_pkg::NUM_LANES-1:0]    error_in,
    output logic [switch_pkg::NUM_LANES-1:0]    error_out
);

    fifo_if ingress_if [switch_pkg::NUM_LANES] ();
    fifo_if egress_if  [switch_pkg::NUM_LANES] ();

    for (genvar i = 0; i < switch_pkg::NUM_LANES; i++) begin : g_lane

        // Ingress FIFO, filled from the outside
        fifo u_ingress_fifo (
            .clk      (clk),
            .reset_L  (reset_L),
            .fifo_bus (ingress_if[i].fifo)
        );

        assign ingress_if[i].push    = push_in[i];
        assign ingress_if[i].data_in = data_in[i];
        assign ingress_full[i]       = ingress_if[i].full;
        assign error_in[i]           = ingress_if[i].error;

        // Egress FIFO, drained from the outside
        fifo u_egress_fifo (
            .clk      (clk),
            .reset_L  (reset_L),
            .fifo_bus (egress_if[i].fifo)
        );

        assign egress_if[i].pop = pop_out[i];
        assign data_out[i]      = egress_if[i].data_out;
        assign egress_empty[i]  = egress_if[i].empty;
        assign error_out[i]     = egress_if[i].error;

    end

    // Moves one flit per cycle from the ingress reader side to the egress writer side
    round_robin_arbiter u_arbiter (
        .clk     (clk),
        .reset_L (reset_L),
        .ingress (ingress_if),
        .egress  (egress_if)
    );

endmodule

// File: hdl/round_robin_arbiter.sv
`timescale 1ns/1ps

module round_robin_arbiter (
    input  logic   clk,
    input  logic   reset_L,
    fifo_if.reader ingress [switch_pkg::NUM_LANES],
    fifo_if.writer egress  [switch_pkg::NUM_LANES]
);

    logic [switch_pkg::NUM_LANES-1:0] in_empty;
    logic [switch_pkg::NUM_LANES-1:0] out_almost_full;
    switch_pkg::flit_t                in_data [switch_pkg::NUM_LANES];

    logic                             pause;
    logic [switch_pkg::LANE_BITS-1:0] rr_ptr;        // Lane searched first
    logic [switch_pkg::LANE_BITS-1:0] grant_lane;
    logic                             grant_valid;
    logic [switch_pkg::LANE_BITS-1:0] idx;
    logic                             found;

    logic                             flight_valid;  // A flit left an ingress FIFO last cycle
    logic [switch_pkg::LANE_BITS-1:0] flight_lane;   // ...and this is where it came from
    switch_pkg::flit_t                flight_flit;

    // Interface arrays cannot take a variable index, so flatten them per lane
    for (genvar i = 0; i < switch_pkg::NUM_LANES; i++) begin : g_lane
        assign in_empty[i]        = ingress[i].empty;
        assign in_data[i]         = ingress[i].data_out;
        assign out_almost_full[i] = egress[i].almost_full;

        assign ingress[i].pop = grant_valid && (int'(grant_lane) == i);

        assign egress[i].push    = flight_valid && (int'(flight_flit.dest) == i);
        assign egress[i].data_in = flight_flit;
    end

    // Any egress near full stalls the whole switch
    assign pause = |out_almost_full;

    // First non-empty lane at or after the pointer
    always_comb begin
        found      = 1'b0;
        grant_lane = rr_ptr;
        idx        = rr_ptr;
        for (int k = 0; k < switch_pkg::NUM_LANES; k++) begin
            idx = rr_ptr + k[switch_pkg::LANE_BITS-1:0];
            if (!found && !in_empty[idx]) begin
                found      = 1'b1;
                grant_lane = idx;
            end
        end
    end

    assign grant_valid = found && !pause;

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            rr_ptr <= '0;
        end else if (grant_valid) begin
            rr_ptr <= grant_lane + 1'b1;      // Winner goes to the back of the line
        end
    end

    // In-flight stage, the ingress read register holds the flit during this cycle
    always_ff @(posedge clk) begin
        if (!reset_L) begin
            flight_valid <= 1'b0;
        end else begin
            flight_valid <= grant_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_valid) begin
            flight_lane <= grant_lane;
        end
    end

    assign flight_flit = in_data[flight_lane];

endmodule

// File: hdl/switch_pkg.sv
package switch_pkg;

    // Lane count and the width of a lane index
    localparam int NUM_LANES = 4;
    localparam int LANE_BITS = 2;

    // FIFO sizing, shared by every ingress and egress FIFO
    localparam int FIFO_DEPTH = 4;
    localparam int ADDR_BITS  = 2;    // Pointer width, wraps at FIFO_DEPTH
    localparam int COUNT_BITS = 3;    // Wide enough to hold FIFO_DEPTH itself

    // Status flag thresholds on the occupancy count
    localparam int ALMOST_EMPTY_LEVEL = 1;   // almost_empty when count equals this
    localparam int ALMOST_FULL_LEVEL  = 2;   // almost_full from here up to one below depth

    // One flit is a single six bit word.
    // The top two bits steer it to an egress lane, the rest rides along.
    typedef struct packed {
        logic [LANE_BITS-1:0] dest;       // Destination lane
        logic [3:0]           payload;
    } flit_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build and run the packet switch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module packet_switch_tb -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vpacket_switch_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: src.f
hdl/switch_pkg.sv
hdl/fifo_if.sv
hdl/dual_port_memory.sv
hdl/fifo.sv
hdl/round_robin_arbiter.sv
hdl/packet_switch.sv
tests/packet_switch_checker.sv
tests/packet_switch_tb.sv

// File: tests/packet_switch_checker.sv
`timescale 1ns/1ps

module packet_switch_checker (
    input logic clk,
    input logic reset_L,
    input logic push,
    input logic pop,
    input logic empty,
    input logic almost_full,
    input logic full,
    input logic error
);

    full_not_empty: assert property (@(posedge clk) disable iff (!reset_L)
        !(full && empty))
        else $error("FIFO flags full and empty together");

    // Pulse must trace back to a refused push or pop one edge earlier
    error_has_cause: assert property (@(posedge clk) disable iff (!reset_L)
        error |-> $past((push && full) || (pop && empty)))
        else $error("FIFO error without a refused operation");

    almost_full_not_empty: assert property (@(posedge clk) disable iff (!reset_L)
        almost_full |-> !empty)
        else $error("FIFO almost_full while empty");

endmodule

bind fifo packet_switch_checker u_checker (
    .clk         (clk),
    .reset_L     (reset_L),
    .push        (fifo_bus.push),
    .pop         (fifo_bus.pop),
    .empty       (fifo_bus.empty),
    .almost_full (fifo_bus.almost_full),
    .full        (fifo_bus.full),
    .error       (fifo_bus.error)
);

// File: tests/packet_switch_tb.sv
`timescale 1ns/1ps

module packet_switch_tb;

    logic                             clk;
    logic                             reset_L;
    logic [switch_pkg::NUM_LANES-1:0] push_in;
    switch_pkg::flit_t                data_in [switch_pkg::NUM_LANES];
    logic [switch_pkg::NUM_LANES-1:0] ingress_full;
    logic [switch_pkg::NUM_LANES-1:0] pop_out;
    switch_pkg::flit_t                data_out [switch_pkg::NUM_LANES];
    logic [switch_pkg::NUM_LANES-1:0] egress_empty;
    logic [switch_pkg::NUM_LANES-1:0] error_in;
    logic [switch_pkg::NUM_LANES-1:0] error_out;

    switch_pkg::flit_t                expect_q [16][$];   // Index is source * 4 + destination
    switch_pkg::flit_t                last_flit [switch_pkg::NUM_LANES];  // Held after last pop
    logic [15:0]                      lfsr = 16'd63204;
    logic [1:0]                       seq [switch_pkg::NUM_LANES];
    logic [switch_pkg::NUM_LANES-1:0] pop_pend = '0;      // Pops accepted on the last edge
    logic [switch_pkg::NUM_LANES-1:0] err_in_exp = '0;
    logic [switch_pkg::NUM_LANES-1:0] err_out_exp = '0;
    int                               errors = 0;
    int                               checks = 0;
    int                               cycles = 0;

    packet_switch DUT (
        .clk          (clk),
        .reset_L      (reset_L),
        .push_in      (push_in),
        .data_in      (data_in),
        .ingress_full (ingress_full),
        .pop_out      (pop_out),
        .data_out     (data_out),
        .egress_empty (egress_empty),
        .error_in     (error_in),
        .error_out    (error_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // Cycle budget of each test, reset first
    function automatic int run_length();
        return 3 + 2 + 128 + 260 + 40 + 5 + 90;
    endfunction

    // Expected flit for a pop on an egress lane, taken from the queue of the named source
    function automatic bit model_predict(input int lane, input switch_pkg::flit_t seen,
                                         output switch_pkg::flit_t expected);
        int q;
        q = int'(seen.payload[3:2]) * switch_pkg::NUM_LANES + lane;
        if (expect_q[q].size() == 0) begin
            return 1'b0;
        end
        expected = expect_q[q].pop_front();
        return 1'b1;
    endfunction

    function automatic int model_pending();
        int n;
        n = 0;
        for (int q = 0; q < 16; q++) begin
            n += expect_q[q].size();
        end
        return n;
    endfunction

    task automatic check_flit(input string what, input switch_pkg::flit_t expected,
                              input switch_pkg::flit_t got);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail at %0d ns: %s expected %h got %h", $time, what, expected, got);
        end
    endtask

    task automatic check_flags(input string what,
                               input logic [switch_pkg::NUM_LANES-1:0] expected,
                               input logic [switch_pkg::NUM_LANES-1:0] got);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail at %0d ns: %s expected %b got %b", $time, what, expected, got);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // Source lane in payload[3:2], running count in payload[1:0]
    task automatic drive_push(input int lane, input int dest);
        switch_pkg::flit_t f;
        f.dest        = dest[switch_pkg::LANE_BITS-1:0];
        f.payload     = {lane[1:0], seq[lane]};
        push_in[lane] = 1'b1;
        data_in[lane] = f;
        if (!ingress_full[lane]) begin
            seq[lane] = seq[lane] + 2'd1;
        end
    endtask

    task automatic drain();
        while (model_pending() > 0) begin
            pop_out = ~egress_empty;              // Only lanes that hold a flit
            tick();
        end
        pop_out = '0;
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    // Model update and compare, all on values from before the edge
    always @(posedge clk) begin : compare
        switch_pkg::flit_t expected;
        if (reset_L) begin
            for (int i = 0; i < switch_pkg::NUM_LANES; i++) begin
                if (push_in[i] && !ingress_full[i]) begin
                    expect_q[i * switch_pkg::NUM_LANES + int'(data_in[i].dest)]
                        .push_back(data_in[i]);
                end
                if (pop_pend[i]) begin
                    if (model_predict(i, data_out[i], expected)) begin
                        check_flit("data_out", expected, data_out[i]);
                        last_flit[i] = expected;
                    end else begin
                        errors++;
                        $display("Fail at %0d ns: egress %0d delivered %h with no matching push",
                                 $time, i, data_out[i]);
                    end
                end
            end
            check_flags("error_in", err_in_exp, error_in);
            check_flags("error_out", err_out_exp, error_out);
        end
        pop_pend    = pop_out & ~egress_empty;
        err_in_exp  = push_in & ingress_full;     // Refused operations pulse one edge later
        err_out_exp = pop_out & egress_empty;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 2 * run_length()) begin
            $display("Timeout: the run did not finish within %0d cycles", 2 * run_length());
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        int                mark;
        int                refused;
        reset_L = 1'b0;
        push_in = '0;
        pop_out = '0;
        for (int i = 0; i < switch_pkg::NUM_LANES; i++) begin
            data_in[i] = '0;
            seq[i]     = '0;
        end
        repeat (3) @(posedge clk);
        #1 reset_L = 1'b1;

        mark = errors;
        check_flags("egress_empty", 4'b1111, egress_empty);
        check_flags("ingress_full", 4'b0000, ingress_full);
        check_flags("error_in", 4'b0000, error_in);
        check_flags("error_out", 4'b0000, error_out);
        report_test("1 reset state", mark);

        // Every source to every destination, one flit at a time
        mark = errors;
        for (int src = 0; src < switch_pkg::NUM_LANES; src++) begin
            for (int d = 0; d < switch_pkg::NUM_LANES; d++) begin
                drive_push(src, d);
                tick();
                push_in = '0;
                while (egress_empty[d]) tick();
                pop_out[d] = 1'b1;
                tick();
                pop_out = '0;
                tick();
            end
        end
        report_test("2 single flits", mark);

        mark = errors;
        repeat (200) begin
            push_in = '0;
            for (int i = 0; i < switch_pkg::NUM_LANES; i++) begin
                if (random_bits(1) == 1 && !ingress_full[i]) begin
                    drive_push(i, random_bits(2));
                end
                pop_out[i] = random_bits(1) == 1 && !egress_empty[i];
            end
            tick();
        end
        push_in = '0;
        drain();
        tick();
        report_test("3 random traffic", mark);

        // Lane 1 to itself with the egress left alone until ingress overflows
        mark = errors;
        refused = 0;
        for (int n = 0; n < 10; n++) begin
            if (ingress_full[1]) refused++;
            drive_push(1, 1);
            tick();
        end
        push_in = '0;
        check_flags("ingress_full", 4'b0010, ingress_full);
        if (refused == 0) begin
            errors++;
            $display("Lane 1 never reported full, so no push was refused");
        end
        drain();
        tick();
        report_test("4 ingress overflow", mark);

        mark = errors;
        pop_out[2] = 1'b1;
        tick();
        pop_out = '0;
        check_flags("error_out", 4'b0100, error_out);
        tick();
        check_flags("error_out", 4'b0000, error_out);
        check_flit("data_out after empty pop", last_flit[2], data_out[2]);
        report_test("5 empty pop", mark);

        // Fill with no pops, pause must keep every egress from refusing a push
        mark = errors;
        repeat (40) begin
            push_in = '0;
            for (int i = 0; i < switch_pkg::NUM_LANES; i++) begin
                if (!ingress_full[i]) drive_push(i, random_bits(2));
            end
            tick();
        end
        push_in = '0;
        repeat (4) tick();
        drain();
        tick();
        report_test("6 back-pressure", mark);

        repeat (2) tick();
        $display("Summary: 6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
